//--- common/kd_pkg.sv
// K-d tree search definitions
`default_nettype none

package kd_pkg;

  // Patch geometry
  localparam int DIM_COUNT = 5;                    // Coordinates per patch
  localparam int COORD_W   = 11;                   // Signed coordinate width
  localparam int PATCH_W   = DIM_COUNT * COORD_W;  // 55 bits, coordinate d at [11*d +: 11]

  // Node word as it arrives on node_wdata
  //   [2:0]   dimension index
  //   [10:3]  don't care
  //   [21:11] signed median
  localparam int NODE_W    = 22;
  localparam int IDX_W     = 3;                    // Stored dimension index width
  localparam int IDX_LSB   = 0;                    // Index field position
  localparam int MED_LSB   = 11;                   // Median field low bit
  localparam int MED_MSB   = MED_LSB + COORD_W - 1; // Median field high bit, 21

  // Reset index points past the last dimension
  // Slicing with it yields a zero coordinate
  localparam logic [IDX_W-1:0] IDX_RESET = 3'd7;

  // Leaf index and the path register through the pipeline
  // Tree depth is limited to this width
  localparam int LEAF_W    = 8;

endpackage : kd_pkg

`default_nettype wire

//--- hdl/kd_load_ctrl.sv
// Node load address decoder
`timescale 1ns/1ps
`default_nettype none

module kd_load_ctrl #(
  parameter int DEPTH = 6                         // Tree levels, 1 to 8
) (
  input  wire logic                      clk,
  input  wire logic                      rst_n,
  input  wire logic                      load_en,     // Load window from the host
  input  wire logic                      node_we,     // Node word strobe
  output logic      [DEPTH-1:0]          wr_level,    // One-hot level write enable
  output logic      [kd_pkg::LEAF_W-1:0] wr_offset,   // Node position inside the level
  output logic                           tree_loaded  // Set once every node was written
);

  localparam int NODE_COUNT = (1 << DEPTH) - 1;   // Internal nodes in the tree

  logic                        wr_strobe;          // Accepted write
  logic [kd_pkg::LEAF_W-1:0]   node_addr;          // Breadth-first node counter
  logic [kd_pkg::LEAF_W:0]     addr_p1;            // Heap-style index, root is 1
  logic [DEPTH-1:0]            level_hot;          // Level of the current address
  logic                        last_node;          // Counter sits on the final node

  assign wr_strobe = load_en & node_we;
  assign addr_p1   = {1'b0, node_addr} + 1'b1;
  assign last_node = (node_addr == kd_pkg::LEAF_W'(NODE_COUNT - 1));

  // Level is the position of the leading one in addr_p1
  // Offset drops that leading one
  always_comb begin
    level_hot = '0;
    wr_offset = '0;
    for (int lvl = 0; lvl < DEPTH; lvl++) begin
      if ((addr_p1 >= (kd_pkg::LEAF_W + 1)'(1 << lvl)) &&
          (addr_p1 <  (kd_pkg::LEAF_W + 1)'(2 << lvl))) begin
        level_hot[lvl] = 1'b1;
        wr_offset      = kd_pkg::LEAF_W'(addr_p1 - (kd_pkg::LEAF_W + 1)'(1 << lvl));
      end
    end
  end

  assign wr_level = wr_strobe ? level_hot : '0;    // Only one level sees the strobe

  // Address counter, wraps after the last node
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      node_addr <= '0;
    end else if (wr_strobe) begin
      if (last_node) begin
        node_addr <= '0;                           // Next write sequence starts at the root
      end else begin
        node_addr <= node_addr + 1'b1;
      end
    end
  end

  // Loaded flag, sticky until reset
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      tree_loaded <= 1'b0;
    end else if (wr_strobe && last_node) begin
      tree_loaded <= 1'b1;                         // Rises with the final write
    end
  end

endmodule : kd_load_ctrl

`default_nettype wire

//--- kd_tree/kd_level.sv
// K-d tree pipeline level
`timescale 1ns/1ps
`default_nettype none

module kd_level #(
  parameter int LEVEL = 0                         // Depth of this stage, root is 0
) (
  input  wire logic                       clk,
  input  wire logic                       rst_n,
  input  wire logic                       wr_en,       // Level write strobe from load ctrl
  input  wire logic [kd_pkg::LEAF_W-1:0]  wr_offset,   // Node within this level
  input  wire logic [kd_pkg::NODE_W-1:0]  node_wdata,  // Index and median word
  input  wire logic                       in_valid,    // Patch present at this level
  input  wire logic [kd_pkg::PATCH_W-1:0] in_patch,
  input  wire logic [kd_pkg::LEAF_W-1:0]  in_path,     // Decisions so far, selects the node
  output logic                            out_valid,
  output logic      [kd_pkg::PATCH_W-1:0] out_patch,
  output logic      [kd_pkg::LEAF_W-1:0]  out_path     // Path with this level's decision
);

  localparam int NODES = 1 << LEVEL;              // Nodes held at this depth

  // Node storage, one entry per node in the level
  logic        [kd_pkg::IDX_W-1:0]   idx_mem [NODES];
  logic signed [kd_pkg::COORD_W-1:0] med_mem [NODES];

  // Read side of the current node
  logic        [kd_pkg::IDX_W-1:0]   rd_idx;
  logic signed [kd_pkg::COORD_W-1:0] rd_med;
  logic signed [kd_pkg::COORD_W-1:0] sel_coord;    // Coordinate picked by rd_idx
  logic                              go_right;     // Decision bit, 1 is right

  // Node write, breadth-first order gives the offset
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int n = 0; n < NODES; n++) begin
        idx_mem[n] <= kd_pkg::IDX_RESET;          // Invalid dimension, slices to zero
        med_mem[n] <= '0;
      end
    end else if (wr_en) begin
      for (int n = 0; n < NODES; n++) begin
        if (wr_offset == kd_pkg::LEAF_W'(n)) begin
          idx_mem[n] <= node_wdata[kd_pkg::IDX_LSB +: kd_pkg::IDX_W];
          med_mem[n] <= node_wdata[kd_pkg::MED_MSB:kd_pkg::MED_LSB];
        end
      end
    end
  end

  // Node lookup
  // Path bits above LEVEL are always zero here
  always_comb begin
    rd_idx = kd_pkg::IDX_RESET;
    rd_med = '0;
    for (int n = 0; n < NODES; n++) begin
      if (in_path == kd_pkg::LEAF_W'(n)) begin
        rd_idx = idx_mem[n];
        rd_med = med_mem[n];
      end
    end
  end

  // Coordinate slice
  // Index 5 to 7 leaves the coordinate at zero
  always_comb begin
    sel_coord = '0;
    for (int d = 0; d < kd_pkg::DIM_COUNT; d++) begin
      if (rd_idx == kd_pkg::IDX_W'(d)) begin
        sel_coord = in_patch[d*kd_pkg::COORD_W +: kd_pkg::COORD_W];
      end
    end
  end

  // Signed compare, ties go right
  assign go_right = !(sel_coord < rd_med);

  // Control part of the stage register
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
      out_path  <= '0;
    end else begin
      out_valid <= in_valid;
      out_path  <= {in_path[kd_pkg::LEAF_W-2:0], go_right}; // Child index at next level
    end
  end

  // Patch payload follows along
  always_ff @(posedge clk) begin
    out_patch <= in_patch;
  end

endmodule : kd_level

`default_nettype wire

//--- hdl/kd_tree_search.sv
// K-d tree search top
`timescale 1ns/1ps
`default_nettype none

module kd_tree_search #(
  parameter int DEPTH = 6                         // Internal node levels, 1 to 8
) (
  input  wire logic                       clk,
  input  wire logic                       rst_n,
  input  wire logic                       load_en,      // Host load window
  input  wire logic                       node_we,      // Node word strobe
  input  wire logic [kd_pkg::NODE_W-1:0]  node_wdata,   // Node word, breadth-first
  input  wire logic                       patch_valid,  // One-cycle patch strobe
  input  wire logic [kd_pkg::PATCH_W-1:0] patch_in,
  output logic                            tree_loaded,  // All nodes written once
  output logic                            result_valid, // Strobe DEPTH cycles after entry
  output logic      [kd_pkg::LEAF_W-1:0]  leaf_index    // Leaf reached by the patch
);

  // Load path
  logic [DEPTH-1:0]          wr_level;            // One-hot, gated by the write strobe
  logic [kd_pkg::LEAF_W-1:0] wr_offset;

  // Pipeline chain, entry g feeds level g
  logic                       valid_chain [DEPTH+1];
  logic [kd_pkg::PATCH_W-1:0] patch_chain [DEPTH+1];
  logic [kd_pkg::LEAF_W-1:0]  path_chain  [DEPTH+1];

  kd_load_ctrl #(
    .DEPTH       (DEPTH)
  ) u_load_ctrl (
    .clk         (clk),
    .rst_n       (rst_n),
    .load_en     (load_en),
    .node_we     (node_we),
    .wr_level    (wr_level),
    .wr_offset   (wr_offset),
    .tree_loaded (tree_loaded)
  );

  // Root sees the raw patch and an empty path
  assign valid_chain[0] = patch_valid;
  assign patch_chain[0] = patch_in;
  assign path_chain[0]  = '0;

  // One level per clock down the tree
  for (genvar g = 0; g < DEPTH; g++) begin : g_level
    kd_level #(
      .LEVEL      (g)
    ) u_level (
      .clk        (clk),
      .rst_n      (rst_n),
      .wr_en      (wr_level[g]),
      .wr_offset  (wr_offset),
      .node_wdata (node_wdata),
      .in_valid   (valid_chain[g]),
      .in_patch   (patch_chain[g]),
      .in_path    (path_chain[g]),
      .out_valid  (valid_chain[g+1]),
      .out_patch  (patch_chain[g+1]),
      .out_path   (path_chain[g+1])
    );
  end

  // Last level's path is the leaf number
  assign result_valid = valid_chain[DEPTH];
  assign leaf_index   = path_chain[DEPTH];

endmodule : kd_tree_search

`default_nettype wire

//--- tb/tb_kd_tree_search.sv
// K-d tree search testbench
`timescale 1ns/1ps
`default_nettype none

module tb_kd_tree_search;

  localparam int DEPTH    = 6;
  localparam int NODES    = (1 << DEPTH) - 1;     // 63 internal nodes
  localparam int MAX_OPS  = 64;

  logic                       clk;
  logic                       rst_n;
  logic                       load_en;
  logic                       node_we;
  logic [kd_pkg::NODE_W-1:0]  node_wdata;
  logic                       patch_valid;
  logic [kd_pkg::PATCH_W-1:0] patch_in;
  logic                       tree_loaded;
  logic                       result_valid;
  logic [kd_pkg::LEAF_W-1:0]  leaf_index;

  // Reference copy of the tree in breadth-first order
  int m_idx [NODES];
  int m_med [NODES];
  int m_ptr;                                      // Next node the model writes

  // Parsed stimulus file
  string                     op_tag  [MAX_OPS];
  logic [kd_pkg::NODE_W-1:0] op_word [MAX_OPS];
  int                        op_num  [MAX_OPS];   // Repeat count or random patch count
  int                        op_c    [MAX_OPS][kd_pkg::DIM_COUNT];
  int                        op_leaf [MAX_OPS];
  int                        op_line [MAX_OPS];
  int                        n_ops;

  // Expected results in send order
  int    exp_leaf_q  [$];
  int    exp_cycle_q [$];
  string exp_name_q  [$];

  int          cycle;
  int          limit;                             // Cycle limit from the file length
  int          acc_writes;                        // Accepted node writes since reset
  int          errors;
  logic [31:0] rng;

  kd_tree_search #(
    .DEPTH        (DEPTH)
  ) DUT (
    .clk          (clk),
    .rst_n        (rst_n),
    .load_en      (load_en),
    .node_we      (node_we),
    .node_wdata   (node_wdata),
    .patch_valid  (patch_valid),
    .patch_in     (patch_in),
    .tree_loaded  (tree_loaded),
    .result_valid (result_valid),
    .leaf_index   (leaf_index)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;                        // 4 ns period
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Walk the model tree from the root down
  function automatic int predict_leaf(input logic [kd_pkg::PATCH_W-1:0] p);
    int                        path;
    int                        node;
    int                        coord;
    logic signed [kd_pkg::COORD_W-1:0] c;
    path = 0;
    for (int lvl = 0; lvl < DEPTH; lvl++) begin
      node  = (1 << lvl) - 1 + path;
      coord = 0;                                  // Index 5 to 7 compares zero
      if (m_idx[node] < kd_pkg::DIM_COUNT) begin
        c     = p[m_idx[node]*kd_pkg::COORD_W +: kd_pkg::COORD_W];
        coord = int'(c);
      end
      path = path * 2 + ((coord < m_med[node]) ? 0 : 1); // Ties go right
    end
    return path;
  endfunction

  function automatic logic [kd_pkg::PATCH_W-1:0] pack_patch(input int i);
    logic [kd_pkg::PATCH_W-1:0] p;
    p = '0;
    for (int d = 0; d < kd_pkg::DIM_COUNT; d++) begin
      p[d*kd_pkg::COORD_W +: kd_pkg::COORD_W] = kd_pkg::COORD_W'(op_c[i][d]);
    end
    return p;
  endfunction

  // Cycle count and run limit
  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (limit > 0 && cycle >= limit) begin
      $display("timeout: no end of test after %0d cycles", limit);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  // Load flag and result checks
  always @(posedge clk) begin
    if (!rst_n) begin
      acc_writes <= 0;
    end else if (load_en && node_we) begin
      acc_writes <= acc_writes + 1;
    end
    if (rst_n && (tree_loaded !== (acc_writes >= NODES))) begin
      $display("error tree_loaded after %0d writes: expected %0d, actual %0d",
               acc_writes, (acc_writes >= NODES), tree_loaded);
      errors = errors + 1;
    end
    if (rst_n && result_valid === 1'b1) begin
      if (exp_leaf_q.size() == 0) begin
        $display("result_valid rose with no patch outstanding, leaf %0d", leaf_index);
        errors = errors + 1;
      end else begin
        if (leaf_index !== kd_pkg::LEAF_W'(exp_leaf_q[0])) begin
          $display("error %s: expected %0d, actual %0d",
                   exp_name_q[0], exp_leaf_q[0], leaf_index);
          errors = errors + 1;
        end
        if (cycle != exp_cycle_q[0]) begin
          $display("error %s latency: expected cycle %0d, actual %0d",
                   exp_name_q[0], exp_cycle_q[0], cycle);
          errors = errors + 1;
        end
        void'(exp_leaf_q.pop_front());
        void'(exp_cycle_q.pop_front());
        void'(exp_name_q.pop_front());
      end
    end
  end

  // Result is due DEPTH+1 monitor cycles after the strobe
  task automatic send_patch(input logic [kd_pkg::PATCH_W-1:0] p, input int leaf,
                            input string name);
    @(posedge clk);
    patch_valid <= 1'b1;
    patch_in    <= p;
    exp_leaf_q.push_back(leaf);
    exp_cycle_q.push_back(cycle + DEPTH + 1);
    exp_name_q.push_back(name);
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk);
      patch_valid <= 1'b0;
    end
  endtask

  task automatic drain();
    while (exp_leaf_q.size() > 0) begin
      @(posedge clk);
    end
  endtask

  // Model pointer wraps like the load counter
  task automatic write_nodes(input logic [kd_pkg::NODE_W-1:0] word, input int cnt);
    logic signed [kd_pkg::COORD_W-1:0] med;
    med = word[21:11];
    for (int k = 0; k < cnt; k++) begin
      @(posedge clk);
      load_en    <= 1'b1;
      node_we    <= 1'b1;
      node_wdata <= word;
      m_idx[m_ptr] = int'(word[2:0]);
      m_med[m_ptr] = int'(med);
      m_ptr = (m_ptr == NODES - 1) ? 0 : m_ptr + 1;
    end
  endtask

  task automatic stop_load();
    @(posedge clk);
    load_en <= 1'b0;
    node_we <= 1'b0;
  endtask

  task automatic random_phase(input int count);
    logic [kd_pkg::PATCH_W-1:0] p;
    logic [kd_pkg::COORD_W-1:0] c;
    for (int k = 0; k < count; k++) begin
      for (int d = 0; d < kd_pkg::DIM_COUNT; d++) begin
        rng = xorshift(rng);
        c   = rng[12] ? rng[10:0] : kd_pkg::COORD_W'(int'(rng[3:0]) - 8); // Near medians
        p[d*kd_pkg::COORD_W +: kd_pkg::COORD_W] = c;
      end
      send_patch(p, predict_leaf(p), $sformatf("random %0d", k));
      rng = xorshift(rng);
      if (rng[1:0] != 2'd0) begin
        idle(int'(rng[1:0]));                     // Gap of 0 to 3 cycles
      end
    end
    idle(1);
  endtask

  task automatic read_stimulus();
    int    fd;
    int    r;
    int    want;
    int    lines;
    string tag;
    string rest;
    fd    = $fopen("tb/kd_stimulus.txt", "r");
    lines = 0;
    n_ops = 0;
    if (fd == 0) begin
      $display("cannot open tb/kd_stimulus.txt");
      errors = errors + 1;
    end else begin
      while ($fscanf(fd, " %s", tag) == 1) begin
        lines = lines + 1;
        if (tag == "#") begin
          r = $fgets(rest, fd);
        end else begin
          op_tag[n_ops]  = tag;
          op_line[n_ops] = lines;
          if (tag == "W") begin
            want = 2;
            r    = $fscanf(fd, "%h %d", op_word[n_ops], op_num[n_ops]);
          end else if (tag == "P") begin
            want = 6;
            r    = $fscanf(fd, "%d %d %d %d %d %d", op_c[n_ops][0], op_c[n_ops][1],
                           op_c[n_ops][2], op_c[n_ops][3], op_c[n_ops][4], op_leaf[n_ops]);
          end else begin
            want = 1;
            r    = $fscanf(fd, "%d", op_num[n_ops]);
          end
          if (r != want) begin
            $display("stimulus line %0d has missing or bad fields", lines);
            errors = errors + 1;
          end
          n_ops = n_ops + 1;
        end
      end
      $fclose(fd);
    end
    limit = 20 * lines + 2000;
  endtask

  initial begin
    logic loading;
    rst_n       = 1'b0;
    load_en     = 1'b0;
    node_we     = 1'b0;
    node_wdata  = '0;
    patch_valid = 1'b0;
    patch_in    = '0;
    cycle       = 0;
    limit       = 0;
    acc_writes  = 0;
    errors      = 0;
    m_ptr       = 0;
    loading     = 1'b0;
    rng         = 32'ha36ef6a3;
    for (int n = 0; n < NODES; n++) begin
      m_idx[n] = int'(kd_pkg::IDX_RESET);
      m_med[n] = 0;
    end
    read_stimulus();

    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    if (result_valid !== 1'b0 || tree_loaded !== 1'b0) begin
      $display("outputs not low after reset");
      errors = errors + 1;
    end

    // Strobes outside the load window must not reach the tree
    for (int k = 0; k < 5; k++) begin
      @(posedge clk);
      node_we    <= 1'b1;
      node_wdata <= 22'h3ff800 | 22'(k);
    end
    @(posedge clk);
    node_we <= 1'b0;

    // Every decision goes right in the unloaded tree
    for (int k = 0; k < 4; k++) begin
      op_c[MAX_OPS-1][0] = 100 * k - 150;
      for (int d = 1; d < kd_pkg::DIM_COUNT; d++) begin
        op_c[MAX_OPS-1][d] = -d * k;
      end
      send_patch(pack_patch(MAX_OPS - 1), (1 << DEPTH) - 1, $sformatf("reset %0d", k));
    end
    idle(1);

    for (int i = 0; i < n_ops; i++) begin
      if (op_tag[i] == "W") begin
        if (!loading) begin
          idle(1);
          drain();
          loading = 1'b1;
        end
        write_nodes(op_word[i], op_num[i]);
      end else begin
        if (loading) begin
          stop_load();
          loading = 1'b0;
        end
        if (op_tag[i] == "P") begin
          send_patch(pack_patch(i), op_leaf[i], $sformatf("line %0d", op_line[i]));
        end else if (op_tag[i] == "R") begin
          idle(1);
          random_phase(op_num[i]);
        end else begin
          $display("unknown tag %s on stimulus line %0d", op_tag[i], op_line[i]);
          errors = errors + 1;
        end
      end
    end
    if (loading) begin
      stop_load();
    end
    idle(1);
    drain();
    idle(4);
    @(negedge clk);                               // Last monitor edge has settled

    $display("checks done, %0d errors", errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule : tb_kd_tree_search

`default_nettype wire

//--- tb/kd_stimulus.txt
# Columns: W node_word_hex repeat | P c0 c1 c2 c3 c4 expected_leaf | R random_count
# Coordinates and leaves are signed decimal, node words are hex
W 000000 1
W 3fd801 2
W 032002 4
W 39c003 8
W 003804 16
W 3ff806 32
# Every coordinate equal to its median
P 0 -5 100 -200 7 63
P -1 -6 99 -201 6 1
P 5 -10 200 -300 7 43
P -1024 1023 -1024 1023 -1024 21
P 3 -4 50 -199 -100 53
P -7 -5 100 -500 8 27
# Random patches against the first tree
R 200
# Second tree, last level uses dimension index 5
W 3fe804 1
W 000003 2
W 20c002 4
W 0fa001 8
W 000800 16
W 001805 32
P 0 0 0 0 0 56
P 1 500 -1000 -1 -3 46
P -5 -500 -1001 5 -4 16
P 1023 1023 1023 1023 1023 62
# Random patches against the second tree
R 40

//--- src.f
common/kd_pkg.sv
hdl/kd_load_ctrl.sv
kd_tree/kd_level.sv
hdl/kd_tree_search.sv
tb/tb_kd_tree_search.sv

//--- Makefile
# Verilator build for the k-d tree search testbench

TOP = tb_kd_tree_search

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal -f src.f --top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	grep -q "\*\*\* TEST PASSED \*\*\*" sim.log

clean:
	rm -rf obj_dir sim.log
